// File: source/mixer_config.svh
`ifndef MIXER_CONFIG_SVH
`define MIXER_CONFIG_SVH

// bits per colour channel.
`define MIXER_PIXEL_BITS 8

`define MIXER_LINE_BITS 12
`define MIXER_WORD_IDX_BITS 8

// eight RGB565 pixels fill one memory word.
`define MIXER_PIXELS_PER_WORD 8
`define MIXER_WORD_BITS 128

// per-port queue, count needs one bit more than the pointers.
`define MIXER_FIFO_DEPTH 16
`define MIXER_FIFO_CNT_BITS 5

`endif

// File: source/mixer_pkg.sv
`default_nettype none

`include "mixer_config.svh"

package mixer_pkg;

	typedef logic [`MIXER_PIXEL_BITS-1:0]    channel_t;
	typedef logic [`MIXER_LINE_BITS-1:0]     line_t;
	typedef logic [`MIXER_WORD_IDX_BITS-1:0] word_idx_t;
	typedef logic [`MIXER_WORD_BITS-1:0]     mem_word_t;
	typedef logic [`MIXER_FIFO_CNT_BITS-1:0] fifo_count_t;
	typedef logic [0:0]                      port_id_t;

	// one camera sample as it arrives on the pins.
	typedef struct packed {
		logic     hs;
		logic     vs;
		logic     de;
		channel_t red;
		channel_t green;
		channel_t blue;
	} video_in_t;

	typedef struct packed {
		line_t     line;
		word_idx_t word_idx;
		mem_word_t data; // first pixel in the low bits.
	} capture_word_t;

	typedef struct packed {
		port_id_t      port;
		capture_word_t word;
	} mem_write_t;

	typedef enum logic [1:0] {IDLE, REQUEST, RELEASE} arb_state_t;

endpackage

`default_nettype wire

// File: source/line_capture.sv
`default_nettype none

`include "mixer_config.svh"

module line_capture (
	input  logic                     pclk0,
	input  logic                     vrst,
	input  mixer_pkg::video_in_t     video,
	output logic                     push,
	output mixer_pkg::capture_word_t word
);

	localparam int PX_BITS  = `MIXER_WORD_BITS / `MIXER_PIXELS_PER_WORD;
	localparam int GRP_BITS = $clog2(`MIXER_PIXELS_PER_WORD);

	logic                 de_d;
	logic                 vs_d;
	logic [GRP_BITS-1:0]  pix_cnt;
	mixer_pkg::word_idx_t word_cnt;
	mixer_pkg::line_t     line_cnt;
	mixer_pkg::mem_word_t shift;
	mixer_pkg::mem_word_t packed_word;
	logic [PX_BITS-1:0]   px565;
	logic                 frame_start;
	logic                 line_end;
	logic                 group_done;

	// RGB565 with green on top.
	assign px565 = {
		video.green[`MIXER_PIXEL_BITS-1 -: 6],
		video.red[`MIXER_PIXEL_BITS-1 -: 5],
		video.blue[`MIXER_PIXEL_BITS-1 -: 5]
	};

	// new pixel enters at the top, so the oldest ends up lowest.
	assign packed_word = {px565, shift[`MIXER_WORD_BITS-1:PX_BITS]};

	assign frame_start = video.vs && !vs_d;
	assign line_end    = de_d && !video.de;
	assign group_done  = video.de &&
		(pix_cnt == GRP_BITS'(`MIXER_PIXELS_PER_WORD - 1));

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			de_d     <= 1'b0;
			vs_d     <= 1'b0;
			pix_cnt  <= '0;
			word_cnt <= '0;
			line_cnt <= '0;
			push     <= 1'b0;
		end else begin
			de_d <= video.de;
			vs_d <= video.vs;
			push <= group_done;
			if (frame_start) begin
				pix_cnt  <= '0;
				word_cnt <= '0;
				line_cnt <= '0; // first line after vs is line 0.
			end else if (line_end) begin
				// a partial group at the end of the line is dropped here.
				pix_cnt  <= '0;
				word_cnt <= '0;
				line_cnt <= line_cnt + 1'b1;
			end else if (video.de) begin
				pix_cnt <= pix_cnt + 1'b1; // wraps after eight.
				if (group_done)
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge pclk0) begin
		if (video.de)
			shift <= packed_word;
		if (group_done) begin
			word.line     <= line_cnt;
			word.word_idx <= word_cnt;
			word.data     <= packed_word;
		end
	end

	// a group takes eight de cycles, so pushes are always spaced out.
	push_spacing: assert property (
		@(posedge pclk0) disable iff (vrst)
		push |=> !push
	) else $error("line_capture: push on two consecutive cycles.");

endmodule

`default_nettype wire

// File: source/word_fifo.sv
`default_nettype none

`include "mixer_config.svh"

module word_fifo (
	input  logic                     pclk0,
	input  logic                     vrst,
	input  logic                     push,
	input  mixer_pkg::capture_word_t din,
	input  logic                     pop,
	output mixer_pkg::capture_word_t dout,
	output logic                     empty,
	output mixer_pkg::fifo_count_t   count,
	output logic                     overflow
);

	localparam int PTR_BITS = $clog2(`MIXER_FIFO_DEPTH);

	mixer_pkg::capture_word_t mem [`MIXER_FIFO_DEPTH];
	logic [PTR_BITS-1:0]      wr_ptr;
	logic [PTR_BITS-1:0]      rd_ptr;
	mixer_pkg::fifo_count_t   cnt;
	logic                     full;
	logic                     do_push;
	logic                     do_pop;

	assign full    = cnt == mixer_pkg::fifo_count_t'(`MIXER_FIFO_DEPTH);
	assign empty   = cnt == '0;
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign dout  = mem[rd_ptr];
	assign count = cnt;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			cnt      <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
			if (push && full)
				overflow <= 1'b1; // sticky until reset.
		end
	end

	always_ff @(posedge pclk0) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// the arbiter must only pop a queue it has seen non-empty.
	no_pop_empty: assert property (
		@(posedge pclk0) disable iff (vrst)
		pop |-> !empty
	) else $error("word_fifo: pop while empty.");

endmodule

`default_nettype wire

// File: source/frame_arbiter.sv
`default_nettype none

module frame_arbiter (
	input  logic                     pclk0,
	input  logic                     vrst,
	input  mixer_pkg::capture_word_t head0,
	input  mixer_pkg::capture_word_t head1,
	input  logic                     empty0,
	input  logic                     empty1,
	input  mixer_pkg::fifo_count_t   count0,
	input  mixer_pkg::fifo_count_t   count1,
	output logic                     pop0,
	output logic                     pop1,
	output logic                     mem_req,
	input  logic                     mem_ack,
	output mixer_pkg::mem_write_t    mem_wr
);

	mixer_pkg::arb_state_t    state;
	mixer_pkg::capture_word_t head_sel;
	logic                     take;
	logic                     pick1;

	// fuller queue wins, port 0 on a tie.
	assign take     = (state == mixer_pkg::IDLE) && !(empty0 && empty1);
	assign pick1    = (count1 > count0) || empty0;
	assign head_sel = pick1 ? head1 : head0;

	assign pop0    = take && !pick1;
	assign pop1    = take && pick1;
	assign mem_req = state == mixer_pkg::REQUEST;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			state <= mixer_pkg::IDLE;
		end else begin
			case (state)
				mixer_pkg::IDLE: begin
					if (take)
						state <= mixer_pkg::REQUEST;
				end
				mixer_pkg::REQUEST: begin
					if (mem_ack)
						state <= mixer_pkg::RELEASE; // drops req.
				end
				mixer_pkg::RELEASE: begin
					// wait for the writer to drop ack before the next word.
					if (!mem_ack)
						state <= mixer_pkg::IDLE;
				end
				default: state <= mixer_pkg::IDLE;
			endcase
		end
	end

	// word is latched together with the pop.
	always_ff @(posedge pclk0) begin
		if (take) begin
			mem_wr.port <= pick1;
			mem_wr.word <= head_sel;
		end
	end

	wr_stable: assert property (
		@(posedge pclk0) disable iff (vrst)
		(mem_req && $past(mem_req)) |-> $stable(mem_wr)
	) else $error("frame_arbiter: mem_wr changed during mem_req.");

	req_hold: assert property (
		@(posedge pclk0) disable iff (vrst)
		(mem_req && !mem_ack) |=> mem_req
	) else $error("frame_arbiter: mem_req dropped before mem_ack.");

endmodule

`default_nettype wire

// File: source/mixer_top.sv
`default_nettype none

module mixer_top (
	input  logic                  pclk0,
	input  logic                  vrst,
	input  mixer_pkg::video_in_t  port0,
	input  mixer_pkg::video_in_t  port1,
	output logic                  mem_req,
	input  logic                  mem_ack,
	output mixer_pkg::mem_write_t mem_wr,
	output logic                  overflow0,
	output logic                  overflow1
);

	logic                     push0;
	logic                     push1;
	mixer_pkg::capture_word_t cap0;
	mixer_pkg::capture_word_t cap1;
	mixer_pkg::capture_word_t head0;
	mixer_pkg::capture_word_t head1;
	logic                     empty0;
	logic                     empty1;
	mixer_pkg::fifo_count_t   count0;
	mixer_pkg::fifo_count_t   count1;
	logic                     pop0;
	logic                     pop1;

	line_capture u_cap0 (
		.pclk0 (pclk0),
		.vrst  (vrst),
		.video (port0),
		.push  (push0),
		.word  (cap0)
	);

	line_capture u_cap1 (
		.pclk0 (pclk0),
		.vrst  (vrst),
		.video (port1),
		.push  (push1),
		.word  (cap1)
	);

	word_fifo u_fifo0 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push0),
		.din      (cap0),
		.pop      (pop0),
		.dout     (head0),
		.empty    (empty0),
		.count    (count0),
		.overflow (overflow0)
	);

	word_fifo u_fifo1 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push1),
		.din      (cap1),
		.pop      (pop1),
		.dout     (head1),
		.empty    (empty1),
		.count    (count1),
		.overflow (overflow1)
	);

	frame_arbiter u_arb (
		.pclk0   (pclk0),
		.vrst    (vrst),
		.head0   (head0),
		.head1   (head1),
		.empty0  (empty0),
		.empty1  (empty1),
		.count0  (count0),
		.count1  (count1),
		.pop0    (pop0),
		.pop1    (pop1),
		.mem_req (mem_req),
		.mem_ack (mem_ack),
		.mem_wr  (mem_wr)
	);

endmodule

`default_nettype wire

// File: tb/mixer_tb_tasks.svh
localparam int PX_BITS = `MIXER_WORD_BITS / `MIXER_PIXELS_PER_WORD;

// galois LFSR, one step per bit taken.
task automatic draw_bits(inout logic [15:0] state, input int n, output logic [15:0] value);
	int i;
	value = '0;
	for (i = 0; i < n; i++) begin
		value = {value[14:0], state[0]};
		state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	end
endtask

task automatic draw_pixel(output mixer_pkg::video_in_t v);
	logic [15:0] r;
	v = '0;
	v.de = 1'b1;
	draw_bits(pix_lfsr, 8, r);
	v.red = r[7:0];
	draw_bits(pix_lfsr, 8, r);
	v.green = r[7:0];
	draw_bits(pix_lfsr, 8, r);
	v.blue = r[7:0];
endtask

function automatic logic [PX_BITS-1:0] rgb565(input mixer_pkg::video_in_t v);
	return {v.green[7:2], v.red[7:3], v.blue[7:3]}; // green on top.
endfunction

// collects pixels and queues an expected word once eight are in.
task automatic model_pixel(input int p, input mixer_pkg::video_in_t v);
	mixer_pkg::mem_write_t w;
	acc[p][PX_BITS*nacc[p] +: PX_BITS] = rgb565(v);
	nacc[p]++;
	if (nacc[p] == `MIXER_PIXELS_PER_WORD) begin
		w.port          = mixer_pkg::port_id_t'(p);
		w.word.line     = line_no[p];
		w.word.word_idx = widx[p];
		w.word.data     = acc[p];
		if (p == 0)
			exp0.push_back(w);
		else
			exp1.push_back(w);
		widx[p]++;
		nacc[p] = 0;
	end
endtask

task automatic end_of_line(input int p);
	line_no[p]++;
	widx[p] = '0;
	nacc[p] = 0; // leftover pixels are lost.
endtask

task automatic check_write(input string name, input mixer_pkg::mem_write_t got,
		input mixer_pkg::mem_write_t want);
	if (got !== want) begin
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
		errors++;
	end
endtask

task automatic check_port(input string name, input mixer_pkg::port_id_t got,
		input mixer_pkg::port_id_t want);
	if (got !== want) begin
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
		errors++;
	end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
	if (got !== want) begin
		$display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, want);
		errors++;
	end
endtask

// File: tb/mixer_tb.sv
`default_nettype none

`include "mixer_config.svh"

module mixer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// pixel cycles of all tests together.
	localparam int PIX_CYCLES  = 21 + 2 * 32 + 3 * 24 + 160 + 16;
	localparam int WATCHDOG_NS = PIX_CYCLES * 10 * 4 + 20000;

	logic                  pclk0;
	logic                  vrst;
	mixer_pkg::video_in_t  port0;
	mixer_pkg::video_in_t  port1;
	logic                  mem_req;
	logic                  mem_ack;
	mixer_pkg::mem_write_t mem_wr;
	logic                  overflow0;
	logic                  overflow1;

	int                    errors;
	logic [15:0]           pix_lfsr;
	logic [15:0]           ack_lfsr;
	int                    ack_delay;
	logic                  ack_random;
	logic                  ack_hold;
	logic                  mon_en;
	logic                  req_d;
	mixer_pkg::mem_write_t wr_d;
	mixer_pkg::mem_write_t rx [$];
	mixer_pkg::mem_write_t exp0 [$];
	mixer_pkg::mem_write_t exp1 [$];
	mixer_pkg::line_t      line_no [2];
	mixer_pkg::word_idx_t  widx [2];
	int                    nacc [2];
	mixer_pkg::mem_word_t  acc [2];

	`include "mixer_tb_tasks.svh"

	mixer_top UUT (
		.pclk0     (pclk0),
		.vrst      (vrst),
		.port0     (port0),
		.port1     (port1),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_wr    (mem_wr),
		.overflow0 (overflow0),
		.overflow1 (overflow1)
	);

	initial begin
		pclk0 = 1'b0;
		forever #5 pclk0 = ~pclk0;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Verification failed");
		$finish;
	end

	// frame-memory writer side of the four-phase handshake.
	initial begin : responder
		logic [15:0] d;
		mem_ack = 1'b0;
		forever begin
			@(posedge pclk0);
			if (mem_req === 1'b1 && !mem_ack) begin
				while (ack_hold)
					@(posedge pclk0);
				if (ack_random)
					draw_bits(ack_lfsr, 3, d);
				else
					d = 16'(ack_delay);
				repeat (d) @(posedge pclk0);
				rx.push_back(mem_wr);
				mem_ack <= 1'b1;
				do @(posedge pclk0); while (mem_req);
				mem_ack <= 1'b0;
			end
		end
	end

	always @(posedge pclk0) begin
		if (mon_en) begin
			if (mem_req && req_d)
				check_write("mem_wr", mem_wr, wr_d); // held while req is up.
			if (mem_req && !req_d)
				check_flag("mem_ack", mem_ack, 1'b0);
		end
		req_d <= mem_req;
		wr_d  <= mem_wr;
	end

	task automatic drive_line(input logic en0, input logic en1, input int npix);
		mixer_pkg::video_in_t v0;
		mixer_pkg::video_in_t v1;
		mixer_pkg::video_in_t blank;
		int i;
		blank = '0;
		for (i = 0; i < npix; i++) begin
			v0 = blank;
			v1 = blank;
			if (en0) begin
				draw_pixel(v0);
				model_pixel(0, v0);
			end
			if (en1) begin
				draw_pixel(v1);
				model_pixel(1, v1);
			end
			@(posedge pclk0);
			port0 <= v0;
			port1 <= v1;
		end
		for (i = 0; i < 6; i++) begin
			blank.hs = (i < 2);
			@(posedge pclk0);
			port0 <= blank;
			port1 <= blank;
		end
		if (en0)
			end_of_line(0);
		if (en1)
			end_of_line(1);
	endtask

	task automatic frame_sync();
		mixer_pkg::video_in_t v;
		int i;
		v = '0;
		for (i = 0; i < 4; i++) begin
			v.vs = (i < 2);
			@(posedge pclk0);
			port0 <= v;
			port1 <= v;
		end
		for (i = 0; i < 2; i++) begin
			line_no[i] = '0;
			widx[i]    = '0;
			nacc[i]    = 0;
		end
	endtask

	task automatic wait_writes();
		int cycles;
		int total;
		total  = exp0.size() + exp1.size();
		cycles = 0;
		while (rx.size() < total && cycles < 2000) begin
			@(posedge pclk0);
			cycles++;
		end
		if (rx.size() < total) begin
			$display("timed out at %0t ns with %0d of %0d writes received",
				$time, rx.size(), total);
			errors++;
		end
		repeat (32) @(posedge pclk0); // quiet window so extra writes show up.
	endtask

	task automatic compare_writes(input logic port0_only);
		mixer_pkg::mem_write_t got;
		mixer_pkg::mem_write_t want;
		while (rx.size() > 0) begin
			got = rx.pop_front();
			if (port0_only)
				check_port("mem_wr.port", got.port, 1'b0);
			if (got.port == 1'b0 && exp0.size() > 0) begin
				want = exp0.pop_front();
				check_write("mem_wr", got, want);
			end else if (got.port == 1'b1 && exp1.size() > 0) begin
				want = exp1.pop_front();
				check_write("mem_wr", got, want);
			end else begin
				$display("unexpected write from port %0d, line %0d, word %0d",
					got.port, got.word.line, got.word.word_idx);
				errors++;
			end
		end
		if (exp0.size() + exp1.size() > 0) begin
			$display("%0d expected words never arrived", exp0.size() + exp1.size());
			errors++;
		end
		exp0.delete();
		exp1.delete();
	endtask

	task automatic reset_values();
		int i;
		for (i = 0; i < 4; i++) begin
			@(posedge pclk0);
			if (i > 0) begin
				check_flag("mem_req", mem_req, 1'b0);
				check_flag("overflow0", overflow0, 1'b0);
				check_flag("overflow1", overflow1, 1'b0);
			end
		end
		vrst <= 1'b0;
		repeat (2) @(posedge pclk0);
		check_flag("mem_req", mem_req, 1'b0);
		check_flag("overflow0", overflow0, 1'b0);
		check_flag("overflow1", overflow1, 1'b0);
	endtask

	task automatic single_port_line();
		frame_sync();
		drive_line(1'b1, 1'b0, 21); // two full words and five spare pixels.
		wait_writes();
		compare_writes(1'b1);
	endtask

	task automatic dual_port_lines();
		ack_delay = 3; // slower writer lets both queues build up.
		frame_sync();
		drive_line(1'b1, 1'b1, 32);
		drive_line(1'b1, 1'b1, 32);
		wait_writes();
		compare_writes(1'b0);
		ack_delay = 1;
	endtask

	task automatic random_ack_handshake();
		int i;
		ack_random = 1'b1;
		for (i = 0; i < 3; i++)
			drive_line(1'b1, 1'b1, 24);
		wait_writes();
		compare_writes(1'b0);
		ack_random = 1'b0;
	endtask

	task automatic queue_overflow();
		int i;
		ack_hold = 1'b1;
		drive_line(1'b1, 1'b0, 160);
		// only the word in flight and the sixteen queued get through.
		for (i = 0; i < 3; i++)
			void'(exp0.pop_back());
		check_flag("overflow0", overflow0, 1'b1);
		check_flag("overflow1", overflow1, 1'b0);
		ack_hold = 1'b0;
		wait_writes();
		compare_writes(1'b1);
	endtask

	task automatic frame_restart();
		frame_sync();
		drive_line(1'b1, 1'b1, 16);
		wait_writes();
		compare_writes(1'b0);
	endtask

	initial begin
		vrst       = 1'b1;
		port0      = '0;
		port1      = '0;
		errors     = 0;
		pix_lfsr   = 16'd58592;
		ack_lfsr   = 16'd58592;
		ack_delay  = 1;
		ack_random = 1'b0;
		ack_hold   = 1'b0;
		mon_en     = 1'b0;
		for (int p = 0; p < 2; p++) begin
			line_no[p] = '0;
			widx[p]    = '0;
			nacc[p]    = 0;
			acc[p]     = '0;
		end
		reset_values();
		mon_en = 1'b1;
		single_port_line();
		dual_port_lines();
		random_ack_handshake();
		queue_overflow();
		frame_restart();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
+incdir+tb
source/mixer_pkg.sv
source/line_capture.sv
source/word_fifo.sv
source/frame_arbiter.sv
source/mixer_top.sv
tb/mixer_tb.sv

// File: Bender.yml
package:
  name: video_mixer

sources:
  - include_dirs:
      - source
    files:
      - source/mixer_pkg.sv
      - source/line_capture.sv
      - source/word_fifo.sv
      - source/frame_arbiter.sv
      - source/mixer_top.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/mixer_tb.sv
